/* design/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  localparam int unsigned INST_W = 32;
  localparam int unsigned OPC_W = 7;

  // base opcodes, bits [6:0]
  localparam logic [OPC_W-1:0] OP_LUI = 7'b0110111;
  localparam logic [OPC_W-1:0] OP_AUIPC = 7'b0010111;
  localparam logic [OPC_W-1:0] OP_JAL = 7'b1101111;
  localparam logic [OPC_W-1:0] OP_JALR = 7'b1100111;
  localparam logic [OPC_W-1:0] OP_BRANCH = 7'b1100011;
  localparam logic [OPC_W-1:0] OP_LOAD = 7'b0000011;
  localparam logic [OPC_W-1:0] OP_STORE = 7'b0100011;
  localparam logic [OPC_W-1:0] OP_IMM = 7'b0010011;
  localparam logic [OPC_W-1:0] OP_REG = 7'b0110011;
  localparam logic [OPC_W-1:0] OP_MISC_MEM = 7'b0001111;
  localparam logic [OPC_W-1:0] OP_SYSTEM = 7'b1110011;

  localparam logic [2:0] F3_FENCE = 3'b000;
  localparam logic [2:0] F3_FENCE_I = 3'b001;

  // imm and rs1 zero, funct3 001, rd zero
  localparam logic [INST_W-1:0] INST_FENCE_I = {17'b0, F3_FENCE_I, 5'b0, OP_MISC_MEM};

  // canonical nop, addi x0, x0, 0
  localparam logic [INST_W-1:0] INST_NOP = {25'b0, OP_IMM};

endpackage

`default_nettype wire

/* design/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam logic [ADDR_W-1:0] PC_INIT = 32'h8000_0000;

  // cache geometry: 4 lines of 2 words
  localparam int unsigned BYTE_OFS_W = 2;
  localparam int unsigned OFS_W = 1;
  localparam int unsigned IDX_W = 2;
  localparam int unsigned TAG_W = ADDR_W - IDX_W - OFS_W - BYTE_OFS_W;
  localparam int unsigned LINES = 2 ** IDX_W;
  localparam int unsigned WORDS = 2 ** OFS_W;

  // instruction class seen by the pc stage
  localparam int unsigned CLS_W = 2;
  localparam logic [CLS_W-1:0] CLS_PLAIN = 2'd0;
  localparam logic [CLS_W-1:0] CLS_CTRL = 2'd1;
  localparam logic [CLS_W-1:0] CLS_LOAD = 2'd2;
  localparam logic [CLS_W-1:0] CLS_FENCE_I = 2'd3;

  // refill fsm states
  localparam int unsigned RF_W = 3;
  localparam logic [RF_W-1:0] RF_IDLE = 3'd0;
  localparam logic [RF_W-1:0] RF_REQ0 = 3'd1;
  localparam logic [RF_W-1:0] RF_WAIT0 = 3'd2;
  localparam logic [RF_W-1:0] RF_REQ1 = 3'd3;
  localparam logic [RF_W-1:0] RF_WAIT1 = 3'd4;

endpackage

`default_nettype wire

/* design/fetch_pc_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_stage (
  input wire clk,
  input wire rst,
  input wire [fetch_pkg::CLS_W-1:0] cls_i,
  input wire accept_i,
  input wire redirect_i,
  input wire [fetch_pkg::ADDR_W-1:0] redirect_pc_i,
  input wire retire_i,
  output logic [fetch_pkg::ADDR_W-1:0] fetch_pc_o,
  output logic fetch_req_o,
  output logic spec_o,
  output logic good_spec_o,
  output logic bad_spec_o,
  output logic flush_o
);

  logic [fetch_pkg::ADDR_W-1:0] pc_q;
  logic [fetch_pkg::ADDR_W-1:0] pc_plus4;
  logic [fetch_pkg::ADDR_W-1:0] btb_q;
  logic btb_valid_q;
  logic stall_q;
  logic spec_q;
  logic [fetch_pkg::ADDR_W-1:0] spec_target_q;
  logic [fetch_pkg::ADDR_W-1:0] spec_fall_q;
  logic resolve;
  logic spec_match;
  logic [fetch_pkg::ADDR_W-1:0] correct_pc;

  assign pc_plus4 = pc_q + fetch_pkg::ADDR_W'(4);
  assign resolve = redirect_i || retire_i;

  // a retire means the control fell through to its pc + 4
  assign spec_match = redirect_i ? (redirect_pc_i == spec_target_q)
                                 : (spec_fall_q == spec_target_q);
  assign correct_pc = redirect_i ? redirect_pc_i : spec_fall_q;

  assign good_spec_o = spec_q && resolve && spec_match;
  assign bad_spec_o = spec_q && resolve && !spec_match;
  assign flush_o = bad_spec_o;
  assign spec_o = spec_q;
  assign fetch_req_o = !stall_q;
  assign fetch_pc_o = pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= fetch_pkg::PC_INIT;
      btb_valid_q <= 1'b0;
      stall_q <= 1'b0;
      spec_q <= 1'b0;
    end else begin
      if (redirect_i) begin
        btb_valid_q <= 1'b1;
      end
      if (bad_spec_o) begin
        // wrong path, restart from the resolved address
        pc_q <= correct_pc;
        spec_q <= 1'b0;
        stall_q <= 1'b0;
      end else begin
        // the oldest pending item is the speculated control
        if (good_spec_o) begin
          spec_q <= 1'b0;
        end else if (stall_q && resolve) begin
          stall_q <= 1'b0;
          pc_q <= redirect_i ? redirect_pc_i : pc_plus4;
        end
        if (accept_i) begin
          case (cls_i)
            fetch_pkg::CLS_CTRL: begin
              if (btb_valid_q && !spec_q) begin
                pc_q <= btb_q;
                spec_q <= 1'b1;
              end else begin
                stall_q <= 1'b1;
              end
            end
            // pc stays on the load until it resolves
            fetch_pkg::CLS_LOAD: stall_q <= 1'b1;
            default: pc_q <= pc_plus4;
          endcase
        end
      end
    end
  end

  // btb target and prediction record
  always_ff @(posedge clk) begin
    if (redirect_i) begin
      btb_q <= redirect_pc_i;
    end
    if (accept_i && cls_i == fetch_pkg::CLS_CTRL && btb_valid_q && !spec_q && !bad_spec_o) begin
      spec_target_q <= btb_q;
      spec_fall_q <= pc_plus4;
    end
  end

endmodule

`default_nettype wire

/* design/icache_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_stage (
  input wire clk,
  input wire rst,
  input wire [fetch_pkg::ADDR_W-1:0] fetch_pc_i,
  input wire fetch_req_i,
  input wire fence_accept_i,
  input wire flush_i,
  output logic hit_valid_o,
  output logic [isa_pkg::INST_W-1:0] hit_inst_o,
  output logic [fetch_pkg::ADDR_W-1:0] bus_araddr_o,
  output logic bus_arvalid_o,
  input wire bus_arready_i,
  input wire [isa_pkg::INST_W-1:0] bus_rdata_i,
  input wire bus_rvalid_i
);

  logic [isa_pkg::INST_W-1:0] data_q [fetch_pkg::LINES][fetch_pkg::WORDS];
  logic [fetch_pkg::TAG_W-1:0] tag_q [fetch_pkg::LINES];
  logic [fetch_pkg::LINES-1:0] valid_q;

  logic [fetch_pkg::RF_W-1:0] state_q;
  logic [fetch_pkg::TAG_W-1:0] rf_tag_q;
  logic [fetch_pkg::IDX_W-1:0] rf_idx_q;

  logic [fetch_pkg::TAG_W-1:0] pc_tag;
  logic [fetch_pkg::IDX_W-1:0] pc_idx;
  logic [fetch_pkg::OFS_W-1:0] pc_ofs;
  logic hit;
  logic miss_start;
  logic second_word;
  logic beat_in;

  assign pc_tag = fetch_pc_i[fetch_pkg::ADDR_W-1 -: fetch_pkg::TAG_W];
  assign pc_idx = fetch_pc_i[fetch_pkg::BYTE_OFS_W+fetch_pkg::OFS_W +: fetch_pkg::IDX_W];
  assign pc_ofs = fetch_pc_i[fetch_pkg::BYTE_OFS_W +: fetch_pkg::OFS_W];

  assign hit = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign hit_valid_o = fetch_req_i && hit;
  assign hit_inst_o = data_q[pc_idx][pc_ofs];

  // no new refill for a pc that is about to be replaced
  assign miss_start = (state_q == fetch_pkg::RF_IDLE) && fetch_req_i && !hit && !flush_i;

  assign second_word = (state_q == fetch_pkg::RF_REQ1) || (state_q == fetch_pkg::RF_WAIT1);
  assign beat_in = bus_rvalid_i &&
                   ((state_q == fetch_pkg::RF_WAIT0) || (state_q == fetch_pkg::RF_WAIT1));

  assign bus_arvalid_o = (state_q == fetch_pkg::RF_REQ0) || (state_q == fetch_pkg::RF_REQ1);
  assign bus_araddr_o = {rf_tag_q, rf_idx_q, second_word, {fetch_pkg::BYTE_OFS_W{1'b0}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= fetch_pkg::RF_IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        fetch_pkg::RF_IDLE: begin
          if (miss_start) begin
            // line is overwritten from here on
            valid_q[pc_idx] <= 1'b0;
            state_q <= fetch_pkg::RF_REQ0;
          end
        end
        fetch_pkg::RF_REQ0: begin
          if (bus_arready_i) begin
            state_q <= fetch_pkg::RF_WAIT0;
          end
        end
        fetch_pkg::RF_WAIT0: begin
          if (bus_rvalid_i) begin
            state_q <= fetch_pkg::RF_REQ1;
          end
        end
        fetch_pkg::RF_REQ1: begin
          if (bus_arready_i) begin
            state_q <= fetch_pkg::RF_WAIT1;
          end
        end
        fetch_pkg::RF_WAIT1: begin
          if (bus_rvalid_i) begin
            valid_q[rf_idx_q] <= 1'b1;
            state_q <= fetch_pkg::RF_IDLE;
          end
        end
        default: state_q <= fetch_pkg::RF_IDLE;
      endcase
      // fence.i drops every line
      if (fence_accept_i) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (miss_start) begin
      rf_tag_q <= pc_tag;
      rf_idx_q <= pc_idx;
      tag_q[pc_idx] <= pc_tag;
    end
    if (beat_in) begin
      data_q[rf_idx_q][second_word] <= bus_rdata_i;
    end
  end

endmodule

`default_nettype wire

/* design/predecode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module predecode_stage (
  input wire clk,
  input wire rst,
  input wire in_valid_i,
  input wire [isa_pkg::INST_W-1:0] in_inst_i,
  input wire [fetch_pkg::ADDR_W-1:0] in_pc_i,
  input wire flush_i,
  output logic pd_ready_o,
  output logic accept_o,
  output logic [fetch_pkg::CLS_W-1:0] cls_o,
  output logic fence_accept_o,
  output logic [isa_pkg::INST_W-1:0] inst_o,
  output logic [fetch_pkg::ADDR_W-1:0] pc_o,
  output logic inst_valid_o,
  input wire inst_ready_i
);

  logic valid_q;
  logic [isa_pkg::INST_W-1:0] inst_q;
  logic [fetch_pkg::ADDR_W-1:0] pc_q;
  logic [isa_pkg::OPC_W-1:0] opcode;

  assign opcode = in_inst_i[isa_pkg::OPC_W-1:0];

  always_comb begin
    cls_o = fetch_pkg::CLS_PLAIN;
    if (in_inst_i == isa_pkg::INST_FENCE_I) begin
      cls_o = fetch_pkg::CLS_FENCE_I;
    end else if (opcode == isa_pkg::OP_LOAD) begin
      cls_o = fetch_pkg::CLS_LOAD;
    end else if (opcode == isa_pkg::OP_JAL || opcode == isa_pkg::OP_JALR ||
                 opcode == isa_pkg::OP_BRANCH || opcode == isa_pkg::OP_SYSTEM) begin
      cls_o = fetch_pkg::CLS_CTRL;
    end
  end

  // room when empty or draining this cycle
  assign pd_ready_o = !valid_q || inst_ready_i;
  assign accept_o = in_valid_i && pd_ready_o && !flush_i;
  assign fence_accept_o = accept_o && (cls_o == fetch_pkg::CLS_FENCE_I);

  // a wrong-path word is never handed over in the flush cycle
  assign inst_valid_o = valid_q && !flush_i;
  assign inst_o = inst_q;
  assign pc_o = pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (accept_o) begin
      valid_q <= 1'b1;
    end else if (inst_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept_o) begin
      inst_q <= in_inst_i;
      pc_q <= in_pc_i;
    end
  end

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input wire clk,
  input wire rst,
  output logic [fetch_pkg::ADDR_W-1:0] bus_araddr_o,
  output logic bus_arvalid_o,
  input wire bus_arready_i,
  input wire [isa_pkg::INST_W-1:0] bus_rdata_i,
  input wire bus_rvalid_i,
  output logic [isa_pkg::INST_W-1:0] inst_o,
  output logic [fetch_pkg::ADDR_W-1:0] pc_o,
  output logic inst_valid_o,
  input wire inst_ready_i,
  input wire redirect_i,
  input wire [fetch_pkg::ADDR_W-1:0] redirect_pc_i,
  input wire retire_i,
  output logic spec_o,
  output logic good_spec_o,
  output logic bad_spec_o
);

  logic [fetch_pkg::ADDR_W-1:0] fetch_pc;
  logic fetch_req;
  logic hit_valid;
  logic [isa_pkg::INST_W-1:0] hit_inst;
  logic [fetch_pkg::CLS_W-1:0] cls;
  logic accept;
  logic fence_accept;
  logic flush;

  fetch_pc_stage u_pc (
    .clk(clk),
    .rst(rst),
    .cls_i(cls),
    .accept_i(accept),
    .redirect_i(redirect_i),
    .redirect_pc_i(redirect_pc_i),
    .retire_i(retire_i),
    .fetch_pc_o(fetch_pc),
    .fetch_req_o(fetch_req),
    .spec_o(spec_o),
    .good_spec_o(good_spec_o),
    .bad_spec_o(bad_spec_o),
    .flush_o(flush)
  );

  icache_stage u_icache (
    .clk(clk),
    .rst(rst),
    .fetch_pc_i(fetch_pc),
    .fetch_req_i(fetch_req),
    .fence_accept_i(fence_accept),
    .flush_i(flush),
    .hit_valid_o(hit_valid),
    .hit_inst_o(hit_inst),
    .bus_araddr_o(bus_araddr_o),
    .bus_arvalid_o(bus_arvalid_o),
    .bus_arready_i(bus_arready_i),
    .bus_rdata_i(bus_rdata_i),
    .bus_rvalid_i(bus_rvalid_i)
  );

  // pd_ready is already folded into accept
  predecode_stage u_predecode (
    .clk(clk),
    .rst(rst),
    .in_valid_i(hit_valid),
    .in_inst_i(hit_inst),
    .in_pc_i(fetch_pc),
    .flush_i(flush),
    .pd_ready_o(),
    .accept_o(accept),
    .cls_o(cls),
    .fence_accept_o(fence_accept),
    .inst_o(inst_o),
    .pc_o(pc_o),
    .inst_valid_o(inst_valid_o),
    .inst_ready_i(inst_ready_i)
  );

endmodule

`default_nettype wire

/* verification/fetch_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_mem_model #(
  parameter int unsigned LATENCY = 2
) (
  input wire clk,
  input wire rst,
  input wire [fetch_pkg::ADDR_W-1:0] araddr_i,
  input wire arvalid_i,
  output logic arready_o,
  output logic [isa_pkg::INST_W-1:0] rdata_o,
  output logic rvalid_o,
  output logic overlap_o
);

  logic [isa_pkg::INST_W-1:0] mem [logic [fetch_pkg::ADDR_W-1:0]];
  logic busy;
  logic sent;
  logic [fetch_pkg::ADDR_W-1:0] addr;
  int unsigned wait_cnt;

  initial begin
    arready_o = 1'b0;
    rdata_o = '0;
    rvalid_o = 1'b0;
    overlap_o = 1'b0;
    busy = 1'b0;
    sent = 1'b0;
    addr = '0;
    wait_cnt = 0;
  end

  task automatic load_word(input logic [fetch_pkg::ADDR_W-1:0] a,
                           input logic [isa_pkg::INST_W-1:0] d);
    mem[a] = d;
  endtask

  // unwritten words read as an addi that encodes their address
  function automatic logic [isa_pkg::INST_W-1:0] word_at(input logic [fetch_pkg::ADDR_W-1:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return {a[31:7] ^ {a[6:0], 18'b0}, isa_pkg::OP_IMM};
  endfunction

  // address side, one request at a time
  always @(posedge clk) begin
    if (rst) begin
      busy = 1'b0;
      sent = 1'b0;
    end else begin
      if (rvalid_o) begin
        busy = 1'b0;
        sent = 1'b0;
      end
      if (arvalid_i && arready_o) begin
        if (busy) begin
          overlap_o <= 1'b1;
        end
        busy = 1'b1;
        sent = 1'b0;
        addr = araddr_i;
        wait_cnt = LATENCY;
      end
    end
  end

  // data beat after the latency, driven on the falling edge
  always @(negedge clk) begin
    rvalid_o <= 1'b0;
    arready_o <= !rst;
    if (busy && !sent) begin
      if (wait_cnt == 0) begin
        rvalid_o <= 1'b1;
        rdata_o <= word_at(addr);
        sent = 1'b1;
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end
  end

endmodule

`default_nettype wire

/* verification/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  localparam int unsigned GOLD_MAX = 256;
  localparam int unsigned COLS = 5;
  localparam int unsigned RESOLVE_DELAY = 2;
  localparam int unsigned ACT_NONE = 0;
  localparam int unsigned ACT_RETIRE = 1;
  localparam int unsigned ACT_REDIRECT = 2;

  logic clk;
  logic rst;
  logic inst_ready;
  logic redirect;
  logic [fetch_pkg::ADDR_W-1:0] redirect_pc;
  logic retire;
  logic [fetch_pkg::ADDR_W-1:0] bus_araddr;
  logic bus_arvalid;
  logic bus_arready;
  logic [isa_pkg::INST_W-1:0] bus_rdata;
  logic bus_rvalid;
  logic overlap;
  logic [isa_pkg::INST_W-1:0] inst;
  logic [fetch_pkg::ADDR_W-1:0] pc;
  logic inst_valid;
  logic spec;
  logic good_spec;
  logic bad_spec;

  logic [31:0] gold [GOLD_MAX*COLS];
  logic [31:0] d_pc [$];
  logic [31:0] d_word [$];
  logic [31:0] d_act [$];
  logic [31:0] d_tgt [$];
  int unsigned req_count [logic [fetch_pkg::ADDR_W-1:0]];
  int unsigned idx;
  int unsigned n_deliv;
  int unsigned err_cnt;
  int unsigned res_cnt;
  bit loaded;
  bit res_pending;
  bit res_fire;
  bit waiting;
  bit skip;
  bit second_beat;
  bit fence_expected;
  bit btb_valid_m;
  logic [fetch_pkg::ADDR_W-1:0] btb_m;
  logic [fetch_pkg::ADDR_W-1:0] line_addr;
  logic [fetch_pkg::ADDR_W-1:0] fence_line;
  logic [31:0] res_act;
  logic [fetch_pkg::ADDR_W-1:0] res_tgt;
  logic exp_good;
  logic exp_bad;

  fetch_unit DUT (
    .clk(clk),
    .rst(rst),
    .bus_araddr_o(bus_araddr),
    .bus_arvalid_o(bus_arvalid),
    .bus_arready_i(bus_arready),
    .bus_rdata_i(bus_rdata),
    .bus_rvalid_i(bus_rvalid),
    .inst_o(inst),
    .pc_o(pc),
    .inst_valid_o(inst_valid),
    .inst_ready_i(inst_ready),
    .redirect_i(redirect),
    .redirect_pc_i(redirect_pc),
    .retire_i(retire),
    .spec_o(spec),
    .good_spec_o(good_spec),
    .bad_spec_o(bad_spec)
  );

  fetch_mem_model #(.LATENCY(2)) u_mem (
    .clk(clk),
    .rst(rst),
    .araddr_i(bus_araddr),
    .arvalid_i(bus_arvalid),
    .arready_o(bus_arready),
    .rdata_o(bus_rdata),
    .rvalid_o(bus_rvalid),
    .overlap_o(overlap)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_value(input string msg);
    err_cnt++;
    $display("FAIL %0t: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_run(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "run aborted");
  endtask

  task automatic check_inst(input logic [isa_pkg::INST_W-1:0] got_inst,
                            input logic [fetch_pkg::ADDR_W-1:0] got_pc,
                            input logic [isa_pkg::INST_W-1:0] exp_inst,
                            input logic [fetch_pkg::ADDR_W-1:0] exp_pc);
    if (got_inst !== exp_inst || got_pc !== exp_pc) begin
      report_value($sformatf("delivered pc %h inst %h, expected pc %h inst %h",
                             got_pc, got_inst, exp_pc, exp_inst));
    end
  endtask

  task automatic check_spec(input logic got_good, input logic got_bad,
                            input logic want_good, input logic want_bad);
    if (got_good !== want_good || got_bad !== want_bad) begin
      report_value($sformatf("good/bad spec %b%b, expected %b%b",
                             got_good, got_bad, want_good, want_bad));
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string what);
    if (got !== want) begin
      report_value($sformatf("%s is %b, expected %b", what, got, want));
    end
  endtask

  task automatic check_addr(input logic [fetch_pkg::ADDR_W-1:0] got,
                            input logic [fetch_pkg::ADDR_W-1:0] want);
    if (got !== want) begin
      report_value($sformatf("bus address %h, expected %h", got, want));
    end
  endtask

  function automatic bit is_ctrl(input logic [isa_pkg::INST_W-1:0] w);
    logic [isa_pkg::OPC_W-1:0] op;
    op = w[isa_pkg::OPC_W-1:0];
    return op == isa_pkg::OP_JAL || op == isa_pkg::OP_JALR ||
           op == isa_pkg::OP_BRANCH || op == isa_pkg::OP_SYSTEM;
  endfunction

  // refill pairs share a line and differ in the word bit only
  task automatic watch_bus();
    if (overlap) begin
      abort_run("memory model saw a second outstanding bus request");
    end
    if (bus_arvalid && bus_arready) begin
      if (!second_beat) begin
        line_addr = {bus_araddr[fetch_pkg::ADDR_W-1:3], 3'b000};
        check_addr(bus_araddr, line_addr);
        if (req_count.exists(line_addr)) begin
          req_count[line_addr]++;
        end else begin
          req_count[line_addr] = 1;
        end
      end else begin
        check_addr(bus_araddr, line_addr | 32'h4);
      end
      second_beat = !second_beat;
    end
  endtask

  task automatic resolve_done();
    check_spec(good_spec, bad_spec, exp_good, exp_bad);
    // spec_o is up only while a prediction waits for its outcome
    check_flag(spec, exp_good || exp_bad, "spec_o at resolution");
    if (res_act == ACT_REDIRECT) begin
      btb_m = res_tgt;
      btb_valid_m = 1'b1;
    end
    res_pending = 1'b0;
    waiting = 1'b0;
    skip = 1'b0;
  endtask

  task automatic take_delivery();
    logic [fetch_pkg::ADDR_W-1:0] actual;
    // wrong-path words are dropped
    if (skip) begin
      return;
    end
    if (waiting) begin
      abort_run("an instruction was delivered while fetch should have been stalled");
    end
    check_inst(inst, pc, d_word[idx], d_pc[idx]);
    if (d_word[idx] == isa_pkg::INST_FENCE_I) begin
      fence_expected = 1'b1;
      fence_line = {d_pc[idx][fetch_pkg::ADDR_W-1:3], 3'b000};
    end
    if (d_act[idx] != ACT_NONE) begin
      res_pending = 1'b1;
      res_cnt = RESOLVE_DELAY;
      res_act = d_act[idx];
      res_tgt = d_tgt[idx];
      actual = (res_act == ACT_REDIRECT) ? res_tgt : d_pc[idx] + 32'd4;
      if (is_ctrl(d_word[idx]) && btb_valid_m) begin
        exp_good = (actual == btb_m);
        exp_bad = !exp_good;
        skip = exp_bad;
      end else begin
        exp_good = 1'b0;
        exp_bad = 1'b0;
        waiting = 1'b1;
      end
    end
    idx++;
  endtask

  initial begin
    int unsigned r;
    rst = 1'b1;
    inst_ready = 1'b0;
    redirect = 1'b0;
    redirect_pc = '0;
    retire = 1'b0;
    idx = 0;
    err_cnt = 0;
    loaded = 1'b0;
    res_pending = 1'b0;
    res_fire = 1'b0;
    waiting = 1'b0;
    skip = 1'b0;
    second_beat = 1'b0;
    fence_expected = 1'b0;
    btb_valid_m = 1'b0;
    void'($urandom(20));
    for (int i = 0; i < GOLD_MAX * COLS; i++) begin
      gold[i] = '0;
    end
    $readmemh("verification/fetch_golden.txt", gold);
    r = 0;
    while (r < GOLD_MAX && gold[r*COLS] != 0) begin
      if (gold[r*COLS] == 1) begin
        u_mem.load_word(gold[r*COLS+1], gold[r*COLS+2]);
      end else begin
        d_pc.push_back(gold[r*COLS+1]);
        d_word.push_back(gold[r*COLS+2]);
        d_act.push_back(gold[r*COLS+3]);
        d_tgt.push_back(gold[r*COLS+4]);
      end
      r++;
    end
    n_deliv = d_pc.size();
    loaded = 1'b1;
    repeat (16) @(negedge clk);
    // everything toward the bus and the back end is quiet in reset
    check_flag(bus_arvalid, 1'b0, "bus_arvalid_o in reset");
    check_flag(inst_valid, 1'b0, "inst_valid_o in reset");
    check_flag(spec, 1'b0, "spec_o in reset");
    check_spec(good_spec, bad_spec, 1'b0, 1'b0);
    rst = 1'b0;

    while (idx < n_deliv) begin
      @(negedge clk);
      inst_ready = ($urandom % 4) != 0;
      redirect = 1'b0;
      retire = 1'b0;
      res_fire = 1'b0;
      if (res_pending) begin
        if (res_cnt == 0) begin
          res_fire = 1'b1;
          redirect = (res_act == ACT_REDIRECT);
          retire = (res_act == ACT_RETIRE);
          redirect_pc = res_tgt;
        end else begin
          res_cnt--;
        end
      end
      @(posedge clk);
      watch_bus();
      if (res_fire) begin
        resolve_done();
      end
      if (inst_valid && inst_ready) begin
        take_delivery();
      end
    end

    if (fence_expected && !(req_count.exists(fence_line) && req_count[fence_line] >= 2)) begin
      abort_run("fence.i did not cause the cached line to be fetched again");
    end
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // generous budget per expected delivery
  initial begin
    wait (loaded);
    repeat (200 * n_deliv + 16) @(posedge clk);
    $display("timeout: the expected deliveries did not complete in time");
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* verification/fetch_golden.txt */
// kind addr word action target, kind 1 = memory word, 2 = expected delivery, 0 = end
// action 0 = none, 1 = retire, 2 = redirect to target
1 80000000 00108093 0 00000000
1 80000004 00002103 0 00000000
1 80000008 00000063 0 00000000
1 8000000c 0000006f 0 00000000
1 80000100 00208093 0 00000000
1 80000104 00308093 0 00000000
1 80000108 00408093 0 00000000
1 8000010c 00508093 0 00000000
1 80000110 00608093 0 00000000
1 80000114 00000063 0 00000000
1 80000200 0000100f 0 00000000
1 80000204 00708093 0 00000000
1 80000208 00000063 0 00000000
1 8000020c 00808093 0 00000000
2 80000000 00108093 0 00000000
2 80000004 00002103 1 00000000
2 80000008 00000063 1 00000000
2 8000000c 0000006f 2 80000100
2 80000100 00208093 0 00000000
2 80000104 00308093 0 00000000
2 80000108 00408093 0 00000000
2 8000010c 00508093 0 00000000
2 80000110 00608093 0 00000000
2 80000114 00000063 2 80000100
2 80000100 00208093 0 00000000
2 80000104 00308093 0 00000000
2 80000108 00408093 0 00000000
2 8000010c 00508093 0 00000000
2 80000110 00608093 0 00000000
2 80000114 00000063 2 80000200
2 80000200 0000100f 0 00000000
2 80000204 00708093 0 00000000
2 80000208 00000063 1 00000000
2 8000020c 00808093 0 00000000
0 00000000 00000000 0 00000000

/* files.f */
design/isa_pkg.sv
design/fetch_pkg.sv
design/fetch_pc_stage.sv
design/icache_stage.sv
design/predecode_stage.sv
design/fetch_unit.sv
verification/fetch_mem_model.sv
verification/fetch_tb.sv
